/* mul_pkg.sv */
package mul_pkg;

  // Operand width of one lane
  localparam int LANE_W = 4;

  // Full product of two lane operands
  localparam int PROD_W = 2 * LANE_W;

  // Two-row final adder covers product bits 7..1
  localparam int ROW_W = PROD_W - 1;

  // One unsigned operand nibble
  typedef logic [LANE_W-1:0] lane_operand_t;

  // One lane product
  typedef logic [PROD_W-1:0] lane_product_t;

  // One row into the final adder, bit 0 has weight 2
  typedef logic [ROW_W-1:0] adder_row_t;

endpackage

/* operand_splitter.sv */
`timescale 1ns/1ps

module operand_splitter #(
  parameter int LANES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [LANES*mul_pkg::LANE_W-1:0]        a_word,
  input  logic [LANES*mul_pkg::LANE_W-1:0]        b_word,
  input  logic                                    dot_mode,
  input  logic                                    in_valid,
  output mul_pkg::lane_operand_t [LANES-1:0]      lane_a,
  output mul_pkg::lane_operand_t [LANES-1:0]      lane_b,
  output logic                                    lane_valid,
  output logic                                    mode
);

  // Capture stage, data only moves on a new word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_a     <= '0;
      lane_b     <= '0;
      mode       <= 1'b0;
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= in_valid;
      if (in_valid) begin
        mode <= dot_mode;
        for (int i = 0; i < LANES; i++) begin
          // Lane 0 gets the low nibble
          lane_a[i] <= a_word[i*mul_pkg::LANE_W +: mul_pkg::LANE_W];
          lane_b[i] <= b_word[i*mul_pkg::LANE_W +: mul_pkg::LANE_W];
        end
      end
    end
  end

endmodule

/* prefix_adder7.sv */
`timescale 1ns/1ps

module prefix_adder7 #(
  parameter bit USE_KOGGE_STONE = 1'b1
) (
  input  mul_pkg::adder_row_t in1,
  input  mul_pkg::adder_row_t in2,
  output mul_pkg::adder_row_t sum
);

  logic [5:0] g;       // No generate needed from the top bit
  logic [6:0] p;
  logic [6:0] carry;   // Carry into each bit

  assign g = in1[5:0] & in2[5:0];
  assign p = in1 ^ in2;

  generate
    if (USE_KOGGE_STONE) begin : g_kogge_stone
      logic [5:0] g1;
      logic [5:2] p1;
      logic [5:0] g2;
      logic [5:4] p2;
      logic [5:0] g3;

      // Level 1, span 1
      assign g1[0] = g[0];
      assign g1[1] = g[1] | (p[1] & g[0]);             // Gray
      for (genvar i = 2; i < 6; i++) begin : g_lvl1
        assign g1[i] = g[i] | (p[i] & g[i-1]);         // Black
        assign p1[i] = p[i] & p[i-1];
      end

      // Level 2, span 2
      assign g2[1:0] = g1[1:0];
      for (genvar i = 2; i < 4; i++) begin : g_lvl2_gray
        assign g2[i] = g1[i] | (p1[i] & g1[i-2]);
      end
      for (genvar i = 4; i < 6; i++) begin : g_lvl2_black
        assign g2[i] = g1[i] | (p1[i] & g1[i-2]);
        assign p2[i] = p1[i] & p1[i-2];
      end

      // Level 3, span 4, gray cells only
      assign g3[3:0] = g2[3:0];
      for (genvar i = 4; i < 6; i++) begin : g_lvl3
        assign g3[i] = g2[i] | (p2[i] & g2[i-4]);
      end

      assign carry = {g3, 1'b0};
    end else begin : g_lookahead
      assign carry[0] = 1'b0;
      for (genvar i = 0; i < 6; i++) begin : g_ripple
        assign carry[i+1] = g[i] | (p[i] & carry[i]);
      end
    end
  endgenerate

  // Carry out of bit 6 dropped, product fits in 8 bits
  assign sum = p ^ carry;

endmodule

/* dadda_mul4_lane.sv */
`timescale 1ns/1ps

module dadda_mul4_lane #(
  parameter bit USE_KOGGE_STONE = 1'b1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mul_pkg::lane_operand_t a,
  input  mul_pkg::lane_operand_t b,
  input  logic                   in_valid,
  output mul_pkg::lane_product_t product,
  output logic                   product_valid
);

  // Partial product rows, row i has weight 2^i
  mul_pkg::lane_operand_t pp0, pp1, pp2, pp3;

  logic s1, s2, s3, s4, s5, s6, s7, s8;
  logic s9, s10, s11, s12, s13, s14, s15, s16;
  logic c1, c2, c3, c4, c5, c6, c7, c8;
  logic c9, c10, c11, c12, c13, c14, c15;

  mul_pkg::adder_row_t row_a;
  mul_pkg::adder_row_t row_b;
  mul_pkg::adder_row_t adder_sum;

  assign pp0 = b & {mul_pkg::LANE_W{a[0]}};
  assign pp1 = b & {mul_pkg::LANE_W{a[1]}};
  assign pp2 = b & {mul_pkg::LANE_W{a[2]}};
  assign pp3 = b & {mul_pkg::LANE_W{a[3]}};

  // Step 1
  assign {c1, s1} = {pp0[2] & pp1[1], pp0[2] ^ pp1[1]};   // col 2
  assign {c2, s2} = {pp0[3] & pp1[2], pp0[3] ^ pp1[2]};   // col 3
  assign {c3, s3} = {pp2[1] & pp3[0], pp2[1] ^ pp3[0]};   // col 3
  assign {c4, s4} = {pp1[3] & pp2[2], pp1[3] ^ pp2[2]};   // col 4
  assign {c5, s5} = {pp2[3] & pp3[2], pp2[3] ^ pp3[2]};   // col 5

  // Step 2
  assign {c6, s6}   = {s2 & s3, s2 ^ s3};                 // col 3
  assign {c7, s7}   = {pp3[1] & s4, pp3[1] ^ s4};         // col 4
  assign {c8, s8}   = {c2 & c3, c2 ^ c3};                 // col 4
  assign {c9, s9}   = {s5 & c4, s5 ^ c4};                 // col 5
  assign {c10, s10} = {pp3[3] & c5, pp3[3] ^ c5};         // col 6

  // Step 3
  assign {c11, s11} = {s7 & s8, s7 ^ s8};                 // col 4
  assign {c12, s12} = {s9 & c7, s9 ^ c7};                 // col 5
  assign {c13, s13} = {s10 & c9, s10 ^ c9};               // col 6

  // Step 4
  assign {c14, s14} = {c8 & s12, c8 ^ s12};               // col 5
  assign {c15, s15} = {s13 & c12, s13 ^ c12};             // col 6
  assign s16 = c10 ^ c13;                                 // col 7, carry is beyond 8 bits

  // Two rows left, columns 1 to 7
  assign row_a = {s16, s15, c11, c6, s6, pp2[0], pp0[1]};
  assign row_b = {c15, c14, s14, s11, c1, s1, pp1[0]};

  prefix_adder7 #(
    .USE_KOGGE_STONE(USE_KOGGE_STONE)
  ) u_final_adder (
    .in1(row_a),
    .in2(row_b),
    .sum(adder_sum)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      product       <= '0;
      product_valid <= 1'b0;
    end else begin
      product_valid <= in_valid;
      if (in_valid) begin
        product <= {adder_sum, pp0[0]};  // Bit 0 needs no adder
      end
    end
  end

endmodule

/* product_collector.sv */
`timescale 1ns/1ps

module product_collector #(
  parameter int LANES = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  mul_pkg::lane_product_t [LANES-1:0]    lane_product,
  input  logic                                  product_valid,
  input  logic                                  mode,
  output logic [LANES*mul_pkg::PROD_W-1:0]      result,
  output logic                                  out_valid
);

  localparam int RES_W = LANES * mul_pkg::PROD_W;
  localparam int SUM_W = mul_pkg::PROD_W + $clog2(LANES);  // Room for the dot sum

  logic             mode_d;
  logic [SUM_W-1:0] dot_sum;
  logic [RES_W-1:0] next_result;

  // Mode trails the operands by the lane latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_d <= 1'b0;
    end else begin
      mode_d <= mode;
    end
  end

  always_comb begin
    dot_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      dot_sum = dot_sum + SUM_W'(lane_product[i]);
    end
  end

  // Dot sum is zero extended, packed mode keeps lane 0 in the low byte
  assign next_result = mode_d ? RES_W'(dot_sum) : lane_product;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= product_valid;
      if (product_valid) begin
        result <= next_result;
      end
    end
  end

endmodule

/* mul_simd_top.sv */
`timescale 1ns/1ps

module mul_simd_top #(
  parameter int LANES           = 4,
  parameter bit USE_KOGGE_STONE = 1'b1
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [LANES*mul_pkg::LANE_W-1:0]   a_word,
  input  logic [LANES*mul_pkg::LANE_W-1:0]   b_word,
  input  logic                               dot_mode,
  input  logic                               in_valid,
  output logic [LANES*mul_pkg::PROD_W-1:0]   result,
  output logic                               out_valid
);

  mul_pkg::lane_operand_t [LANES-1:0] lane_a;
  mul_pkg::lane_operand_t [LANES-1:0] lane_b;
  mul_pkg::lane_product_t [LANES-1:0] lane_product;
  logic                               lane_valid;
  logic                               split_mode;
  logic                               product_valid;

  operand_splitter #(
    .LANES(LANES)
  ) u_splitter (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_word    (a_word),
    .b_word    (b_word),
    .dot_mode  (dot_mode),
    .in_valid  (in_valid),
    .lane_a    (lane_a),
    .lane_b    (lane_b),
    .lane_valid(lane_valid),
    .mode      (split_mode)
  );

  // Lanes run in lockstep, lane 0 speaks for all valids
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    if (i == 0) begin : g_lead
      dadda_mul4_lane #(
        .USE_KOGGE_STONE(USE_KOGGE_STONE)
      ) u_lane (
        .clk          (clk),
        .rst_n        (rst_n),
        .a            (lane_a[i]),
        .b            (lane_b[i]),
        .in_valid     (lane_valid),
        .product      (lane_product[i]),
        .product_valid(product_valid)
      );
    end else begin : g_follow
      dadda_mul4_lane #(
        .USE_KOGGE_STONE(USE_KOGGE_STONE)
      ) u_lane (
        .clk          (clk),
        .rst_n        (rst_n),
        .a            (lane_a[i]),
        .b            (lane_b[i]),
        .in_valid     (lane_valid),
        .product      (lane_product[i]),
        .product_valid()
      );
    end
  end

  product_collector #(
    .LANES(LANES)
  ) u_collector (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_product (lane_product),
    .product_valid(product_valid),
    .mode         (split_mode),
    .result       (result),
    .out_valid    (out_valid)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // Half period high, half low
  end

endmodule

/* mul_simd_assert.sv */
`timescale 1ns/1ps

module mul_simd_assert #(
  parameter int LANES = 4
) (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               in_valid,
  input logic                               out_valid,
  input logic [LANES*mul_pkg::PROD_W-1:0]   result
);

  localparam int LATENCY = 3;  // Splitter, lane, collector

  // Every accepted word comes out after the full pipeline
  a_out_follows_in: assert property (@(posedge clk) disable iff (!rst_n)
    $past(in_valid, LATENCY) |-> out_valid)
    else $error("out_valid missing %0d cycles after in_valid", LATENCY);

  // And nothing comes out without a word behind it
  a_out_has_source: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, LATENCY))
    else $error("out_valid without in_valid %0d cycles earlier", LATENCY);

  // Reset clears out_valid on the next edge
  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> !out_valid)
    else $error("out_valid high while in reset");

  a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(result))
    else $error("result has unknown bits while out_valid is high");

endmodule

bind mul_simd_top mul_simd_assert #(
  .LANES(LANES)
) u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .out_valid(out_valid),
  .result   (result)
);

/* mul_simd_tb.sv */
`timescale 1ns/1ps

module mul_simd_tb;

  localparam int    PERIOD_NS    = 40;
  localparam int    RESET_CYCLES = 4;
  localparam int    LATENCY      = 3;                  // Splitter, lane, collector
  localparam int    WORD_W       = 4 * mul_pkg::LANE_W;
  localparam int    RES_W        = 4 * mul_pkg::PROD_W;
  localparam int    BURST_LEN    = 10;                 // File tail is sent back to back
  localparam string DATA_FILE    = "mul_simd_testdata.txt";

  logic              clk;
  logic              rst_n;
  logic [WORD_W-1:0] a_word;
  logic [WORD_W-1:0] b_word;
  logic              dot_mode;
  logic              in_valid;
  logic [RES_W-1:0]  result;
  logic              out_valid;

  int seed = 32'hef54_2eb5;

  // Vectors as read from the file
  logic [WORD_W-1:0] vec_a[$];
  logic [WORD_W-1:0] vec_b[$];
  logic              vec_mode[$];
  logic [RES_W-1:0]  vec_exp[$];

  logic [RES_W-1:0]  exp_q[$];   // Results still in flight
  int                due_q[$];   // Cycle at which each result is due
  int                cycle = 0;
  bit                loaded = 1'b0;
  logic [RES_W-1:0]  exp_result;
  int                exp_cycle;

  tb_clock_gen #(
    .PERIOD_NS(PERIOD_NS)
  ) u_clk (
    .clk(clk)
  );

  mul_simd_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_word   (a_word),
    .b_word   (b_word),
    .dot_mode (dot_mode),
    .in_valid (in_valid),
    .result   (result),
    .out_valid(out_valid)
  );

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic load_vectors();
    int                fd;
    int                n;
    string             line;
    logic [WORD_W-1:0] a_v;
    logic [WORD_W-1:0] b_v;
    logic              m_v;
    logic [RES_W-1:0]  e_v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", DATA_FILE);
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip blank and header lines
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h", a_v, b_v, m_v, e_v);
          if (n != 4) begin
            $display("Malformed line in %s: %s", DATA_FILE, line);
            abort_run();
          end else begin
            vec_a.push_back(a_v);
            vec_b.push_back(b_v);
            vec_mode.push_back(m_v);
            vec_exp.push_back(e_v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge so the next rising edge samples the word
  task automatic send_word(input int idx);
    a_word   = vec_a[idx];
    b_word   = vec_b[idx];
    dot_mode = vec_mode[idx];
    in_valid = 1'b1;
    exp_q.push_back(vec_exp[idx]);
    due_q.push_back(cycle + LATENCY);
  endtask

  always @(posedge clk) cycle <= cycle + 1;

  // Outputs are read on the falling edge half a cycle after they settle
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid went high at %0t with no word in flight", $time);
        abort_run();
      end else begin
        exp_result = exp_q.pop_front();
        exp_cycle  = due_q.pop_front();
        assert (cycle == exp_cycle) else begin
          $display("Error: time %0t signal out_valid expected cycle %0d actual cycle %0d",
                   $time, exp_cycle, cycle);
          abort_run();
        end
        assert (result === exp_result) else begin
          $display("Error: time %0t signal result expected %h actual %h",
                   $time, exp_result, result);
          abort_run();
        end
      end
    end
  end

  initial begin : stimulus
    int gap;
    a_word   = '0;
    b_word   = '0;
    dot_mode = 1'b0;
    in_valid = 1'b0;
    rst_n    = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (5) @(negedge clk);  // Idle gap with out_valid low
    for (int i = 0; i < vec_a.size(); i++) begin
      @(negedge clk);
      send_word(i);
      if (i >= vec_a.size() - BURST_LEN) begin
        gap = 0;                 // Keeps three words in flight
      end else begin
        gap = $random(seed) & 3;
      end
      repeat (gap) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (LATENCY + 2) @(negedge clk);  // Catch any stray out_valid
    $display("Test OK");
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = vec_a.size() * 5 + 50;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT did not return every result", limit);
    abort_run();
  end

endmodule

/* mul_simd_testdata.txt */
# a_word b_word dot_mode expected_result, all hex, lane 0 is the low nibble
# dot_mode 0 packs lane products, dot_mode 1 gives their sum
0000 0000 0 00000000
ffff ffff 0 e1e1e1e1
ffff 0000 0 00000000
1111 ffff 0 0f0f0f0f
1234 5678 0 050c1520
8421 1248 0 08080808
f0f0 0f0f 0 00000000
abcd 1234 0 0a162434
9e7c 3b5d 0 1b9a239c
2222 3333 0 06060606
7777 7777 0 31313131
8888 8888 0 40404040
fedc ba98 0 a58c7560
0f0f ffff 0 00e100e1
5a5a a5a5 0 32323232
1357 9bdf 0 09214169
3c6e d2a1 0 27183c0e
6b4f 7e9c 0 2a9a24b4
e1e1 e1e1 0 c401c401
0001 000f 0 0000000f
f000 f000 0 e1000000
4321 4321 0 10090401
9999 dddd 0 75757575
c3b2 58e7 0 3c189a0e
ffff ffff 1 00000384
0000 ffff 1 00000000
1111 1111 1 00000004
1234 5678 1 00000046
abcd 1234 1 00000078
fedc ba98 1 00000206
9e7c 3b5d 1 00000174
8888 8888 1 00000100
7777 7777 1 000000c4
e1e1 e1e1 1 0000018a
6b4f 7e9c 1 0000019c
000f 000f 1 000000e1
ffff ffff 0 e1e1e1e1
ffff ffff 1 00000384
1234 5678 0 050c1520
1234 5678 1 00000046
3c6e d2a1 1 00000089
3c6e d2a1 0 27183c0e
1357 9bdf 1 000000d4
5a5a a5a5 0 32323232
5a5a a5a5 1 000000c8
c3b2 58e7 1 000000fc

/* tb.f */
mul_pkg.sv
operand_splitter.sv
prefix_adder7.sv
dadda_mul4_lane.sv
product_collector.sv
mul_simd_top.sv
tb_clock_gen.sv
mul_simd_assert.sv
mul_simd_tb.sv

/* Makefile */
# Verilator flow for the packed multiplier
VERILATOR  ?= verilator
TOP        ?= mul_simd_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
